/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = muldiv_tb
FILELIST = muldiv.f
OBJ_DIR  = obj_dir
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/muldiv_decode.sv */
`timescale 1ns/10ps

module muldiv_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               flush,
    input  muldiv_pkg::md_op_e op,
    input  muldiv_pkg::word_t  src_a,
    input  muldiv_pkg::word_t  src_b,
    input  logic               done,
    output logic               busy,
    output muldiv_pkg::md_op_e op_q,
    output logic               mul_go,
    output logic               div_go,
    output muldiv_pkg::word_t  mag_a,
    output muldiv_pkg::word_t  mag_b,
    output logic               neg_res,
    output logic               neg_rem
);
    import muldiv_pkg::*;

    logic busy_q;
    logic accept;
    logic is_div;
    logic signed_a;
    logic signed_b;
    logic neg_a;
    logic neg_b;

    // busy drops together with done so a new start can be taken that cycle.
    assign busy   = busy_q && !done;
    assign accept = start && !busy;

    always_comb begin
        signed_a = 1'b0;
        signed_b = 1'b0;
        case (op)
            op_mulh, op_div, op_rem: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            op_mulhsu: signed_a = 1'b1;   // rs2 is unsigned.
            default: ;
        endcase
        is_div = op inside {op_div, op_divu, op_rem, op_remu};
        neg_a  = signed_a && src_a[xlen-1];
        neg_b  = signed_b && src_b[xlen-1];
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy_q <= 1'b0;
            mul_go <= 1'b0;
            div_go <= 1'b0;
        end else begin
            mul_go <= accept && !is_div;
            div_go <= accept && is_div;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // operands stay put until the next accepted start.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= op;
            mag_a   <= neg_a ? -src_a : src_a;
            mag_b   <= neg_b ? -src_b : src_b;
            neg_res <= neg_a ^ neg_b;
            neg_rem <= neg_a;   // remainder takes the dividend's sign.
        end
    end

endmodule

/* hdl/muldiv_div_iter.sv */
`timescale 1ns/10ps

module muldiv_div_iter (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               div_go,
    input  muldiv_pkg::word_t  mag_a,
    input  muldiv_pkg::word_t  mag_b,
    input  logic               neg_res,
    input  logic               neg_rem,
    output logic               div_fin,
    output muldiv_pkg::word_t  quotient,
    output muldiv_pkg::word_t  remainder
);
    import muldiv_pkg::*;

    logic             running;
    logic [cnt_w-1:0] cnt;
    logic             last;
    logic             step;
    word_t            pr;        // partial remainder.
    word_t            dq;        // dividend bits out, quotient bits in.
    word_t            src_pr;
    word_t            src_dq;
    logic [xlen:0]    shifted;
    logic [xlen:0]    diff;
    logic             fits;

    assign last = running && (cnt == cnt_w'(iter_count));
    assign step = div_go || (running && !last);

    always_comb begin
        src_pr  = div_go ? '0 : pr;
        src_dq  = div_go ? mag_a : dq;
        shifted = {src_pr, src_dq[xlen-1]};
        diff    = shifted - {1'b0, mag_b};
        fits    = !diff[xlen];   // no borrow, keep the difference.
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            running <= 1'b0;
            cnt     <= '0;
            div_fin <= 1'b0;
        end else begin
            div_fin <= last;
            if (div_go) begin
                running <= 1'b1;
                cnt     <= cnt_w'(1);
            end else if (last) begin
                running <= 1'b0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            pr <= fits ? diff[xlen-1:0] : shifted[xlen-1:0];
            dq <= {src_dq[xlen-2:0], fits};
        end
        if (last) begin
            // divide by zero leaves all ones, so the quotient sign is not applied.
            quotient  <= (neg_res && (mag_b != '0)) ? -dq : dq;
            remainder <= neg_rem ? -pr : pr;
        end
    end

endmodule

/* hdl/muldiv_mul_iter.sv */
`timescale 1ns/10ps

module muldiv_mul_iter (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                mul_go,
    input  muldiv_pkg::word_t   mag_a,
    input  muldiv_pkg::word_t   mag_b,
    input  logic                neg_res,
    output logic                mul_fin,
    output muldiv_pkg::dword_t  product
);
    import muldiv_pkg::*;

    logic             running;
    logic [cnt_w-1:0] cnt;
    logic             last;
    logic             step;
    dword_t           mcand;
    word_t            mplier;
    dword_t           acc;
    dword_t           src_mcand;
    word_t            src_mplier;
    dword_t           src_acc;
    dword_t           sum;

    assign last = running && (cnt == cnt_w'(iter_count));
    assign step = mul_go || (running && !last);

    // first iteration works straight from the decode registers.
    always_comb begin
        src_mcand  = mul_go ? {{xlen{1'b0}}, mag_a} : mcand;
        src_mplier = mul_go ? mag_b : mplier;
        src_acc    = mul_go ? '0 : acc;
        sum        = src_acc + (src_mplier[0] ? src_mcand : '0);
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            running <= 1'b0;
            cnt     <= '0;
            mul_fin <= 1'b0;
        end else begin
            mul_fin <= last;
            if (mul_go) begin
                running <= 1'b1;
                cnt     <= cnt_w'(1);
            end else if (last) begin
                running <= 1'b0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            acc    <= sum;
            mcand  <= src_mcand << 1;
            mplier <= src_mplier >> 1;
        end
        if (last) begin
            product <= neg_res ? -acc : acc;   // magnitudes only, sign fixed here.
        end
    end

endmodule

/* hdl/muldiv_pkg.sv */
package muldiv_pkg;

    // operand width and iteration control.
    localparam int xlen       = 64;
    localparam int iter_count = xlen;   // one bit per cycle.
    localparam int cnt_w      = 7;

    typedef logic [xlen-1:0]   word_t;
    typedef logic [2*xlen-1:0] dword_t;

    // encoded as the funct3 field of the M extension.
    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } md_op_e;

endpackage

/* hdl/muldiv_result.sv */
`timescale 1ns/10ps

module muldiv_result (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  muldiv_pkg::md_op_e op_q,
    input  logic               mul_fin,
    input  muldiv_pkg::dword_t product,
    input  logic               div_fin,
    input  muldiv_pkg::word_t  quotient,
    input  muldiv_pkg::word_t  remainder,
    output logic               done,
    output muldiv_pkg::word_t  result
);
    import muldiv_pkg::*;

    logic  fin;
    word_t sel;

    assign fin = (mul_fin || div_fin) && !flush;

    always_comb begin
        case (op_q)
            op_mul:                      sel = product[xlen-1:0];
            op_mulh, op_mulhsu, op_mulhu: sel = product[2*xlen-1:xlen];
            op_div, op_divu:             sel = quotient;
            default:                     sel = remainder;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= fin;   // single cycle, the units pulse fin once.
            if (fin) begin
                result <= sel;
            end
        end
    end

endmodule

/* hdl/muldiv_top.sv */
`timescale 1ns/10ps

module muldiv_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               flush,
    input  muldiv_pkg::md_op_e op,
    input  muldiv_pkg::word_t  src_a,
    input  muldiv_pkg::word_t  src_b,
    output logic               busy,
    output logic               done,
    output muldiv_pkg::word_t  result
);
    import muldiv_pkg::*;

    md_op_e op_q;
    logic   mul_go;
    logic   div_go;
    word_t  mag_a;
    word_t  mag_b;
    logic   neg_res;
    logic   neg_rem;
    logic   mul_fin;
    logic   div_fin;
    dword_t product;
    word_t  quotient;
    word_t  remainder;

    muldiv_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .flush   (flush),
        .op      (op),
        .src_a   (src_a),
        .src_b   (src_b),
        .done    (done),
        .busy    (busy),
        .op_q    (op_q),
        .mul_go  (mul_go),
        .div_go  (div_go),
        .mag_a   (mag_a),
        .mag_b   (mag_b),
        .neg_res (neg_res),
        .neg_rem (neg_rem)
    );

    muldiv_mul_iter u_mul (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .mul_go  (mul_go),
        .mag_a   (mag_a),
        .mag_b   (mag_b),
        .neg_res (neg_res),
        .mul_fin (mul_fin),
        .product (product)
    );

    muldiv_div_iter u_div (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .div_go    (div_go),
        .mag_a     (mag_a),
        .mag_b     (mag_b),
        .neg_res   (neg_res),
        .neg_rem   (neg_rem),
        .div_fin   (div_fin),
        .quotient  (quotient),
        .remainder (remainder)
    );

    muldiv_result u_result (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .op_q      (op_q),
        .mul_fin   (mul_fin),
        .product   (product),
        .div_fin   (div_fin),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (done),
        .result    (result)
    );

endmodule

/* muldiv.f */
hdl/muldiv_pkg.sv
hdl/muldiv_decode.sv
hdl/muldiv_mul_iter.sv
hdl/muldiv_div_iter.sv
hdl/muldiv_result.sv
hdl/muldiv_top.sv
tb/muldiv_chk.sv
tb/muldiv_tb.sv

/* tb/muldiv_chk.sv */
`timescale 1ns/10ps

module muldiv_chk (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic busy,
    input logic done
);

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held longer than one cycle");

    // an operation must be in flight before it can finish.
    done_needs_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(busy))
        else $error("done rose without busy in the previous cycle");

    no_done_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !done)
        else $error("done seen right after flush");

    // busy only drops together with done or after a flush.
    busy_falls_with_done: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> (done || $past(flush)))
        else $error("busy fell without done or flush");

endmodule

bind muldiv_top muldiv_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .flush (flush),
    .busy  (busy),
    .done  (done)
);

/* tb/muldiv_tb.sv */
`timescale 1ns/10ps

module muldiv_tb;
    import muldiv_pkg::*;

    localparam int          clk_period  = 20;
    localparam int          tab_len     = 52;
    localparam int          done_bound  = 100;   // cycles allowed for one operation.
    localparam int          flush_every = 10;
    localparam logic [31:0] rand_seed   = 32'hd1b4ec34;
    localparam word_t       min_val     = {1'b1, {(xlen-1){1'b0}}};
    localparam word_t       all_ones    = '1;

    logic   clk;
    logic   rst;
    logic   start;
    logic   flush;
    md_op_e op;
    word_t  src_a;
    word_t  src_b;
    logic   busy;
    logic   done;
    word_t  result;

    md_op_e op_tab [tab_len];
    word_t  a_tab [tab_len];
    word_t  b_tab [tab_len];
    word_t  exp_tab [tab_len];
    int     n_used;
    int     value_errs;
    int     other_errs;
    logic   done_seen;
    int     done_count;

    muldiv_top u_muldiv_top (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .flush  (flush),
        .op     (op),
        .src_a  (src_a),
        .src_b  (src_b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #(clk_period / 2) clk = ~clk;

    // RISC-V M results from sign or zero extended 128-bit operands.
    function automatic word_t expected_result(md_op_e f_op, word_t a, word_t b);
        logic signed [2*xlen-1:0] ea;
        logic signed [2*xlen-1:0] eb;
        logic signed [2*xlen-1:0] prod;
        logic signed [2*xlen-1:0] q;
        logic signed [2*xlen-1:0] r;
        logic                     sgn_a;
        logic                     sgn_b;
        sgn_a = f_op inside {op_mulh, op_mulhsu, op_div, op_rem};
        sgn_b = f_op inside {op_mulh, op_div, op_rem};
        ea    = sgn_a ? {{xlen{a[xlen-1]}}, a} : {{xlen{1'b0}}, a};
        eb    = sgn_b ? {{xlen{b[xlen-1]}}, b} : {{xlen{1'b0}}, b};
        prod  = ea * eb;
        if (b == '0) begin
            q = '1;
            r = ea;
        end else if (sgn_b && a == min_val && b == all_ones) begin
            q = ea;   // signed overflow.
            r = '0;
        end else begin
            q = ea / eb;
            r = ea % eb;
        end
        case (f_op)
            op_mul:                       return prod[xlen-1:0];
            op_mulh, op_mulhsu, op_mulhu: return prod[2*xlen-1:xlen];
            op_div, op_divu:              return q[xlen-1:0];
            default:                      return r[xlen-1:0];
        endcase
    endfunction

    task automatic add_entry(md_op_e e_op, word_t a, word_t b);
        op_tab[n_used]  = e_op;
        a_tab[n_used]   = a;
        b_tab[n_used]   = b;
        exp_tab[n_used] = expected_result(e_op, a, b);
        n_used++;
    endtask

    task automatic build_table();
        word_t b;
        add_entry(op_mul, 64'd3, 64'd5);   // first two differ, used for the busy test.
        add_entry(op_div, 64'd100, 64'd7);
        add_entry(op_mul, 64'd0, 64'h1234_5678_9abc_def0);
        add_entry(op_mul, 64'd1, 64'hdead_beef_cafe_f00d);
        add_entry(op_mul, all_ones, all_ones);
        add_entry(op_mul, min_val, all_ones);
        add_entry(op_mulh, min_val, min_val);
        add_entry(op_mulh, all_ones, 64'd1);
        add_entry(op_mulh, 64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff);
        add_entry(op_mulhsu, all_ones, all_ones);
        add_entry(op_mulhsu, 64'd5, all_ones);
        add_entry(op_mulhsu, min_val, 64'd2);
        add_entry(op_mulhu, all_ones, all_ones);
        add_entry(op_mulhu, min_val, 64'd2);
        add_entry(op_div, -64'sd7, 64'd2);
        add_entry(op_rem, -64'sd7, 64'd2);
        add_entry(op_div, 64'd7, -64'sd2);
        add_entry(op_rem, 64'd7, -64'sd2);
        add_entry(op_div, 64'h0123_4567_89ab_cdef, 64'd0);
        add_entry(op_rem, -64'sd42, 64'd0);
        add_entry(op_divu, 64'h0123_4567_89ab_cdef, 64'd0);
        add_entry(op_remu, 64'h0123_4567_89ab_cdef, 64'd0);
        add_entry(op_div, min_val, all_ones);
        add_entry(op_rem, min_val, all_ones);
        add_entry(op_divu, all_ones, 64'd3);
        add_entry(op_remu, all_ones, 64'd10);
        add_entry(op_div, 64'd0, 64'd5);
        add_entry(op_divu, 64'd1, all_ones);
        while (n_used < tab_len) begin
            if ($urandom_range(3, 0) == 0) begin
                b = word_t'($urandom_range(15, 0));   // small divisors, zero included.
            end else begin
                b = {$urandom(), $urandom()};
            end
            add_entry(md_op_e'($urandom_range(7, 0)), {$urandom(), $urandom()}, b);
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic start_op(md_op_e s_op, word_t a, word_t b);
        @(negedge clk);
        op    = s_op;
        src_a = a;
        src_b = b;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done();
        done_seen = 1'b0;
        for (int n = 0; n < done_bound && !done_seen; n++) begin
            @(negedge clk);
            done_seen = done;
        end
    endtask

    task automatic count_dones(int cycles);
        done_count = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (done) done_count++;
        end
    endtask

    task automatic run_entry(int i);
        start_op(op_tab[i], a_tab[i], b_tab[i]);
        wait_done();
        if (!done_seen) begin
            $display("entry %0d: done never arrived", i);
            other_errs++;
        end else begin
            check_word($sformatf("result[%0d]", i), exp_tab[i], result);
            check_flag("busy", 1'b0, busy);
        end
    endtask

    // abort an operation part way through, nothing may complete afterwards.
    task automatic flush_op(int i);
        int wait_cycles;
        // the first flush lands on the finish pulse.
        wait_cycles = (i == flush_every - 1) ? iter_count + 1 : $urandom_range(60, 1);
        start_op(op_tab[i], a_tab[i], b_tab[i]);
        repeat (wait_cycles) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_flag("busy", 1'b0, busy);
        count_dones(done_bound);
        check_flag("done_after_flush", 1'b0, done_count != 0);
    endtask

    task automatic busy_start_test();
        start_op(op_tab[0], a_tab[0], b_tab[0]);
        repeat (10) @(negedge clk);
        check_flag("busy", 1'b1, busy);
        op    = op_tab[1];
        src_a = a_tab[1];
        src_b = b_tab[1];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done();
        if (!done_seen) begin
            $display("start while busy: done never arrived");
            other_errs++;
        end else begin
            check_word("result", exp_tab[0], result);
        end
        count_dones(done_bound);
        check_flag("extra_done", 1'b0, done_count != 0);
    endtask

    initial begin : watchdog
        repeat (tab_len * done_bound + 500) @(posedge clk);
        $display("watchdog expired, the run took longer than its time budget");
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        flush      = 1'b0;
        op         = op_mul;
        src_a      = '0;
        src_b      = '0;
        n_used     = 0;
        value_errs = 0;
        other_errs = 0;
        void'($urandom(rand_seed));
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        check_word("result", '0, result);

        busy_start_test();
        for (int i = 0; i < tab_len; i++) begin
            if (i % flush_every == flush_every - 1) flush_op(i);
            run_entry(i);
        end

        $display("%0d value errors, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
